/* verilog/draw_pkg.sv */
`default_nettype none

package draw_pkg;

    // on-screen coordinates and pixel colour
    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [2:0] colour_t;

    // base width of the triangle
    typedef logic [7:0] diam_t;

    // corners and line positions may fall off screen
    typedef logic signed [9:0] coord_s_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        EDGE_START,
        EDGE_WAIT,
        NEXT_EDGE,
        DONE
    } tri_state_t;

    // height = diameter * 111 / 128, close to sqrt(3)/2
    localparam int HEIGHT_NUM   = 111;
    localparam int HEIGHT_SHIFT = 7;

endpackage

`default_nettype wire

/* verilog/plot_if.sv */
`default_nettype none

// one pixel write per cycle, no back-pressure
interface plot_if;

    draw_pkg::coord_x_t x;
    draw_pkg::coord_y_t y;
    draw_pkg::colour_t  colour;
    logic               plot;

    // drawing engine side
    modport source (
        output x, y, colour, plot
    );

    // controller side
    modport sink (
        input x, y, colour, plot
    );

endinterface

`default_nettype wire

/* verilog/screen_clear.sv */
`default_nettype none

module screen_clear #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic   vif,
    input  logic   rst_n,
    input  logic   go,
    output logic   done,
    plot_if.source px
);

    draw_pkg::coord_x_t cnt_x;
    draw_pkg::coord_y_t cnt_y;
    logic               running;
    logic               row_end;
    logic               last_px;

    assign row_end = (cnt_x == draw_pkg::coord_x_t'(SCREEN_W - 1));
    assign last_px = row_end && (cnt_y == draw_pkg::coord_y_t'(SCREEN_H - 1));

    // raster scan, x fastest
    always_ff @(posedge vif) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt_x   <= '0;
            cnt_y   <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                running <= 1'b1;
                cnt_x   <= '0;
                cnt_y   <= '0;
            end else if (running) begin
                if (last_px) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else if (row_end) begin
                    cnt_x <= '0;
                    cnt_y <= cnt_y + 1'b1;
                end else begin
                    cnt_x <= cnt_x + 1'b1;
                end
            end
        end
    end

    // black at every position while running
    assign px.x      = cnt_x;
    assign px.y      = cnt_y;
    assign px.colour = '0;
    assign px.plot   = running;

endmodule

`default_nettype wire

/* verilog/line_draw.sv */
`default_nettype none

module line_draw #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic               vif,
    input  logic               rst_n,
    input  logic               go,
    input  draw_pkg::coord_s_t x0,
    input  draw_pkg::coord_s_t y0,
    input  draw_pkg::coord_s_t x1,
    input  draw_pkg::coord_s_t y1,
    input  draw_pkg::colour_t  colour,
    output logic               done,
    plot_if.source             px
);

    // error term needs room for twice the largest distance
    typedef logic signed [11:0] err_t;

    draw_pkg::coord_s_t cur_x;
    draw_pkg::coord_s_t cur_y;
    err_t               dx;
    err_t               dy_n;
    err_t               err;
    logic               sx_neg;
    logic               sy_neg;
    logic               running;

    err_t diff_x;
    err_t diff_y;
    err_t abs_x;
    err_t abs_y;
    err_t e2;
    err_t err_next;
    logic step_x;
    logic step_y;
    logic at_end;
    logic visible;

    // distances from the endpoints, sign extended
    assign diff_x = err_t'(x1) - err_t'(x0);
    assign diff_y = err_t'(y1) - err_t'(y0);
    assign abs_x  = (diff_x < 0) ? -diff_x : diff_x;
    assign abs_y  = (diff_y < 0) ? -diff_y : diff_y;

    // one Bresenham step
    assign e2       = err <<< 1;
    assign step_x   = (e2 >= dy_n);
    assign step_y   = (e2 <= dx);
    assign err_next = err + (step_x ? dy_n : err_t'(0)) + (step_y ? dx : err_t'(0));
    assign at_end   = (cur_x == x1) && (cur_y == y1);

    always_ff @(posedge vif) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (go) begin
                running <= 1'b1;
            end else if (running && at_end) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

    // walk state
    always_ff @(posedge vif) begin
        if (go) begin
            cur_x  <= x0;
            cur_y  <= y0;
            dx     <= abs_x;
            dy_n   <= -abs_y;
            err    <= abs_x - abs_y;
            sx_neg <= (diff_x < 0);
            sy_neg <= (diff_y < 0);
        end else if (running && !at_end) begin
            err <= err_next;
            if (step_x) begin
                cur_x <= sx_neg ? cur_x - draw_pkg::coord_s_t'(1)
                                : cur_x + draw_pkg::coord_s_t'(1);
            end
            if (step_y) begin
                cur_y <= sy_neg ? cur_y - draw_pkg::coord_s_t'(1)
                                : cur_y + draw_pkg::coord_s_t'(1);
            end
        end
    end

    // off-screen pixels are skipped, the walk goes on
    assign visible = (cur_x >= 0) && (cur_x < SCREEN_W) &&
                     (cur_y >= 0) && (cur_y < SCREEN_H);

    assign px.x      = cur_x[7:0];
    assign px.y      = cur_y[6:0];
    assign px.colour = colour;
    assign px.plot   = running && visible;

endmodule

`default_nettype wire

/* verilog/triangle_fsm.sv */
`default_nettype none

module triangle_fsm (
    input  logic               vif,
    input  logic               rst_n,
    input  logic               start,
    input  draw_pkg::colour_t  colour,
    input  draw_pkg::coord_x_t centre_x,
    input  draw_pkg::coord_y_t centre_y,
    input  draw_pkg::diam_t    diameter,
    output logic               done,
    output logic               clear_go,
    input  logic               clear_done,
    output logic               line_go,
    input  logic               line_done,
    output draw_pkg::coord_s_t x0,
    output draw_pkg::coord_s_t y0,
    output draw_pkg::coord_s_t x1,
    output draw_pkg::coord_s_t y1,
    output draw_pkg::colour_t  line_colour,
    plot_if.sink               clear_px,
    plot_if.sink               line_px,
    output draw_pkg::coord_x_t vga_x,
    output draw_pkg::coord_y_t vga_y,
    output draw_pkg::colour_t  vga_colour,
    output logic               vga_plot
);

    draw_pkg::tri_state_t state;
    logic [1:0]           edge_idx;

    // corners, latched at start
    draw_pkg::coord_s_t apex_x;
    draw_pkg::coord_s_t apex_y;
    draw_pkg::coord_s_t base_l_x;
    draw_pkg::coord_s_t base_r_x;
    draw_pkg::coord_s_t base_y;

    draw_pkg::coord_s_t cx_s;
    draw_pkg::coord_s_t cy_s;
    draw_pkg::coord_s_t half_d_s;
    draw_pkg::coord_s_t half_h_s;
    logic [15:0]        height_prod;
    logic [15:0]        height_full;

    // corner geometry from the live inputs
    assign cx_s        = draw_pkg::coord_s_t'({2'b00, centre_x});
    assign cy_s        = draw_pkg::coord_s_t'({3'b000, centre_y});
    assign half_d_s    = draw_pkg::coord_s_t'({3'b000, diameter[7:1]});
    assign height_prod = 16'(diameter) * 16'(draw_pkg::HEIGHT_NUM);
    assign height_full = height_prod >> draw_pkg::HEIGHT_SHIFT;
    assign half_h_s    = draw_pkg::coord_s_t'({1'b0, height_full[9:1]});

    always_ff @(posedge vif) begin
        if (state == draw_pkg::IDLE && start) begin
            apex_x      <= cx_s;
            apex_y      <= cy_s - half_h_s;
            base_l_x    <= cx_s - half_d_s;
            base_r_x    <= cx_s + half_d_s;
            base_y      <= cy_s + half_h_s;
            line_colour <= colour;
        end
    end

    always_ff @(posedge vif) begin
        if (!rst_n) begin
            state    <= draw_pkg::IDLE;
            edge_idx <= '0;
            clear_go <= 1'b0;
        end else begin
            clear_go <= 1'b0;
            case (state)
                draw_pkg::IDLE: begin
                    if (start) begin
                        state    <= draw_pkg::CLEAR;
                        clear_go <= 1'b1;
                    end
                end
                draw_pkg::CLEAR: begin
                    if (clear_done) begin
                        state    <= draw_pkg::EDGE_START;
                        edge_idx <= '0;
                    end
                end
                draw_pkg::EDGE_START: begin
                    state <= draw_pkg::EDGE_WAIT;
                end
                draw_pkg::EDGE_WAIT: begin
                    if (line_done) begin
                        state <= draw_pkg::NEXT_EDGE;
                    end
                end
                draw_pkg::NEXT_EDGE: begin
                    if (edge_idx == 2'd2) begin
                        state <= draw_pkg::DONE;
                    end else begin
                        edge_idx <= edge_idx + 1'b1;
                        state    <= draw_pkg::EDGE_START;
                    end
                end
                draw_pkg::DONE: begin
                    // hold until the host lets go
                    if (!start) begin
                        state <= draw_pkg::IDLE;
                    end
                end
                default: begin
                    state <= draw_pkg::IDLE;
                end
            endcase
        end
    end

    assign line_go = (state == draw_pkg::EDGE_START);
    assign done    = (state == draw_pkg::DONE);

    // apex to left, left to right, right to apex
    always_comb begin
        case (edge_idx)
            2'd0: begin
                x0 = apex_x;
                y0 = apex_y;
                x1 = base_l_x;
                y1 = base_y;
            end
            2'd1: begin
                x0 = base_l_x;
                y0 = base_y;
                x1 = base_r_x;
                y1 = base_y;
            end
            default: begin
                x0 = base_r_x;
                y0 = base_y;
                x1 = apex_x;
                y1 = apex_y;
            end
        endcase
    end

    // pixel source follows the active phase
    always_comb begin
        if (state == draw_pkg::CLEAR) begin
            vga_x      = clear_px.x;
            vga_y      = clear_px.y;
            vga_colour = clear_px.colour;
            vga_plot   = clear_px.plot;
        end else begin
            vga_x      = line_px.x;
            vga_y      = line_px.y;
            vga_colour = line_px.colour;
            vga_plot   = line_px.plot;
        end
    end

endmodule

`default_nettype wire

/* verilog/triangle_top.sv */
`default_nettype none

module triangle_top #(
    parameter int SCREEN_W = 160,
    parameter int SCREEN_H = 120
) (
    input  logic               vif,
    input  logic               rst_n,
    input  logic               start,
    input  draw_pkg::colour_t  colour,
    input  draw_pkg::coord_x_t centre_x,
    input  draw_pkg::coord_y_t centre_y,
    input  draw_pkg::diam_t    diameter,
    output logic               done,
    output draw_pkg::coord_x_t vga_x,
    output draw_pkg::coord_y_t vga_y,
    output draw_pkg::colour_t  vga_colour,
    output logic               vga_plot
);

    logic               clear_go;
    logic               clear_done;
    logic               line_go;
    logic               line_done;
    draw_pkg::coord_s_t x0;
    draw_pkg::coord_s_t y0;
    draw_pkg::coord_s_t x1;
    draw_pkg::coord_s_t y1;
    draw_pkg::colour_t  line_colour;

    // pixel writes from each engine
    plot_if clear_px ();
    plot_if line_px ();

    triangle_fsm u_fsm (
        .vif         (vif),
        .rst_n       (rst_n),
        .start       (start),
        .colour      (colour),
        .centre_x    (centre_x),
        .centre_y    (centre_y),
        .diameter    (diameter),
        .done        (done),
        .clear_go    (clear_go),
        .clear_done  (clear_done),
        .line_go     (line_go),
        .line_done   (line_done),
        .x0          (x0),
        .y0          (y0),
        .x1          (x1),
        .y1          (y1),
        .line_colour (line_colour),
        .clear_px    (clear_px.sink),
        .line_px     (line_px.sink),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .vga_plot    (vga_plot)
    );

    screen_clear #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_clear (
        .vif   (vif),
        .rst_n (rst_n),
        .go    (clear_go),
        .done  (clear_done),
        .px    (clear_px.source)
    );

    line_draw #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_line (
        .vif    (vif),
        .rst_n  (rst_n),
        .go     (line_go),
        .x0     (x0),
        .y0     (y0),
        .x1     (x1),
        .y1     (y1),
        .colour (line_colour),
        .done   (line_done),
        .px     (line_px.source)
    );

endmodule

`default_nettype wire

/* tests/triangle_test_seq.sv */
`default_nettype none

module triangle_test_seq (
    input  logic               vif,
    input  logic               rst_n,
    input  logic               done,
    output logic               start,
    output draw_pkg::colour_t  colour,
    output draw_pkg::coord_x_t centre_x,
    output draw_pkg::coord_y_t centre_y,
    output draw_pkg::diam_t    diameter,
    output logic               finished
);

    localparam int DRIVE_DELAY  = 10;
    localparam int RANDOM_TESTS = 20;
    localparam int MAX_HOLD     = 20;

    int unsigned lcg_state;

    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low bits of an LCG are weak, take the upper ones
    function int unsigned rand_below(int unsigned n);
        lcg_state = lcg_next(lcg_state);
        return (lcg_state >> 8) % n;
    endfunction

    task automatic run_triangle(int cx, int cy, int d, int col);
        int hold;
        hold = int'(rand_below(MAX_HOLD + 1));
        @(posedge vif);
        #DRIVE_DELAY;
        centre_x = draw_pkg::coord_x_t'(cx);
        centre_y = draw_pkg::coord_y_t'(cy);
        diameter = draw_pkg::diam_t'(d);
        colour   = draw_pkg::colour_t'(col);
        start    = 1'b1;
        do begin
            @(posedge vif);
            #DRIVE_DELAY;
        end while (done !== 1'b1);
        // keep start up a little while done is shown
        repeat (hold) begin
            @(posedge vif);
            #DRIVE_DELAY;
        end
        start = 1'b0;
        do begin
            @(posedge vif);
            #DRIVE_DELAY;
        end while (done !== 1'b0);
    endtask

    initial begin
        int rx;
        int ry;
        int rd;
        int rc;
        start     = 1'b0;
        colour    = '0;
        centre_x  = '0;
        centre_y  = '0;
        diameter  = '0;
        finished  = 1'b0;
        lcg_state = 32'd45560;
        @(posedge vif);
        while (rst_n !== 1'b1) @(posedge vif);

        // a centred triangle and three near or across the screen edges
        run_triangle(80, 60, 80, 3);
        run_triangle(6, 59, 78, 5);
        run_triangle(112, 47, 88, 6);
        run_triangle(159, 119, 120, 7);

        for (int i = 0; i < RANDOM_TESTS; i++) begin
            rx = int'(rand_below(160));
            ry = int'(rand_below(120));
            rd = 10 + 2 * int'(rand_below(56));
            rc = int'(rand_below(8));
            run_triangle(rx, ry, rd, rc);
        end

        @(posedge vif);
        #DRIVE_DELAY;
        finished = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/triangle_checker.sv */
`default_nettype none

module triangle_checker (
    input logic               vif,
    input logic               rst_n,
    input logic               start,
    input draw_pkg::colour_t  colour,
    input draw_pkg::coord_x_t centre_x,
    input draw_pkg::coord_y_t centre_y,
    input draw_pkg::diam_t    diameter,
    input logic               done,
    input draw_pkg::coord_x_t vga_x,
    input draw_pkg::coord_y_t vga_y,
    input draw_pkg::colour_t  vga_colour,
    input logic               vga_plot
);

    localparam int SCREEN_W   = 160;
    localparam int SCREEN_H   = 120;
    localparam int FRAME_SIZE = SCREEN_W * SCREEN_H;
    localparam int MAX_SHOWN  = 8;

    logic [2:0] model [0:FRAME_SIZE-1];
    logic [2:0] expect_px [0:FRAME_SIZE-1];

    int test_count  = 0;
    int fail_count  = 0;
    int error_count = 0;
    int test_errors = 0;

    int         t_cx;
    int         t_cy;
    int         t_d;
    logic [2:0] t_col;
    logic       prev_start;
    logic       prev_done;
    logic       armed;
    logic       check_reset;

    // never black, so an unwritten position shows up
    function automatic logic [2:0] marker(int addr);
        return 3'((addr % 7) + 1);
    endfunction

    function void plot_ref(int x, int y, logic [2:0] c);
        if (x >= 0 && x < SCREEN_W && y >= 0 && y < SCREEN_H) begin
            expect_px[y * SCREEN_W + x] = c;
        end
    endfunction

    // textbook Bresenham, all octants
    function void line_ref(int x0, int y0, int x1, int y1, logic [2:0] c);
        int x;
        int y;
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        x   = x0;
        y   = y0;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        plot_ref(x, y, c);
        while (x != x1 || y != y1) begin
            e2 = 2 * err;
            if (e2 >= dy) begin
                err = err + dy;
                x   = x + sx;
            end
            if (e2 <= dx) begin
                err = err + dx;
                y   = y + sy;
            end
            plot_ref(x, y, c);
        end
    endfunction

    function void predict_frame(int cx, int cy, int d, logic [2:0] c);
        int half_d;
        int half_h;
        half_d = d >> 1;
        // height about 0.866 of the diameter
        half_h = ((d * 111) >> 7) >> 1;
        for (int i = 0; i < FRAME_SIZE; i++) begin
            expect_px[i] = 3'd0;
        end
        line_ref(cx, cy - half_h, cx - half_d, cy + half_h, c);
        line_ref(cx - half_d, cy + half_h, cx + half_d, cy + half_h, c);
        line_ref(cx + half_d, cy + half_h, cx, cy - half_h, c);
    endfunction

    task automatic report_error(string msg);
        $display("ERROR: %s", msg);
        test_errors++;
        error_count++;
    endtask

    task automatic begin_test();
        for (int i = 0; i < FRAME_SIZE; i++) begin
            model[i] = marker(i);
        end
        t_cx        = int'(centre_x);
        t_cy        = int'(centre_y);
        t_d         = int'(diameter);
        t_col       = colour;
        test_errors = 0;
        armed       = 1'b1;
    endtask

    task automatic finish_test();
        int bad;
        bad = 0;
        predict_frame(t_cx, t_cy, t_d, t_col);
        for (int i = 0; i < FRAME_SIZE; i++) begin
            if (model[i] !== expect_px[i]) begin
                bad++;
                if (bad <= MAX_SHOWN) begin
                    $display("MISMATCH vga_colour at x=%0d y=%0d: got %h, expected %h",
                             i % SCREEN_W, i / SCREEN_W, model[i], expect_px[i]);
                end
            end
        end
        test_errors += bad;
        error_count += bad;
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d: centre (%0d, %0d) diameter %0d colour %0d ok",
                     test_count, t_cx, t_cy, t_d, t_col);
        end else begin
            fail_count++;
            $display("test %0d: centre (%0d, %0d) diameter %0d colour %0d failed, %0d errors",
                     test_count, t_cx, t_cy, t_d, t_col, test_errors);
        end
    endtask

    always @(posedge vif) begin
        if (!rst_n) begin
            prev_start  = 1'b0;
            prev_done   = 1'b0;
            armed       = 1'b0;
            check_reset = 1'b1;
        end else begin
            if (check_reset && done !== 1'b0) begin
                report_error("done is not low after reset");
            end
            check_reset = 1'b0;
            if (start && !prev_start && !done) begin
                begin_test();
            end
            if (vga_plot === 1'b1) begin
                if (vga_x >= SCREEN_W || vga_y >= SCREEN_H) begin
                    report_error($sformatf("pixel plotted off the screen at x=%0d y=%0d",
                                           vga_x, vga_y));
                end else begin
                    model[int'(vga_y) * SCREEN_W + int'(vga_x)] = vga_colour;
                end
            end
            if (done && !prev_done) begin
                if (!armed) begin
                    report_error("done rose again without a new start");
                end else begin
                    finish_test();
                end
                armed = 1'b0;
            end
            if (prev_done && !done && prev_start) begin
                report_error("done fell while start was still high");
            end
            if (done && !start && !prev_start) begin
                report_error("done stayed high after start was dropped");
            end
            prev_start = start;
            prev_done  = done;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_triangle.sv */
`default_nettype none

module tb_triangle;

    localparam int NUM_TESTS       = 24;
    localparam int CYCLES_PER_TEST = 25000;
    localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;
    localparam int RESET_CYCLES    = 8;

    logic               vif;
    logic               rst_n;
    logic               start;
    logic               done;
    logic               finished;
    logic               vga_plot;
    draw_pkg::colour_t  colour;
    draw_pkg::coord_x_t centre_x;
    draw_pkg::coord_y_t centre_y;
    draw_pkg::diam_t    diameter;
    draw_pkg::coord_x_t vga_x;
    draw_pkg::coord_y_t vga_y;
    draw_pkg::colour_t  vga_colour;
    int                 cycle_count = 0;

    initial vif = 1'b0;
    always #50 vif = ~vif;

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge vif);
        #10;
        rst_n = 1'b1;
    end

    triangle_top DUT (
        .vif        (vif),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    triangle_test_seq u_seq (
        .vif      (vif),
        .rst_n    (rst_n),
        .done     (done),
        .start    (start),
        .colour   (colour),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .diameter (diameter),
        .finished (finished)
    );

    triangle_checker u_checker (
        .vif        (vif),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .diameter   (diameter),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    // roughly a clear plus three edges per test, with plenty of slack
    always @(posedge vif) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        wait (finished === 1'b1);
        repeat (2) @(posedge vif);
        $display("tests run %0d of %0d, failed %0d, errors %0d",
                 u_checker.test_count, NUM_TESTS, u_checker.fail_count,
                 u_checker.error_count);
        if (u_checker.test_count == NUM_TESTS && u_checker.fail_count == 0 &&
            u_checker.error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
verilog/draw_pkg.sv
verilog/plot_if.sv
verilog/screen_clear.sv
verilog/line_draw.sv
verilog/triangle_fsm.sv
verilog/triangle_top.sv
tests/triangle_test_seq.sv
tests/triangle_checker.sv
tests/tb_triangle.sv

/* Bender.yml */
package:
  name: triangle_draw

sources:
  - verilog/draw_pkg.sv
  - verilog/plot_if.sv
  - verilog/screen_clear.sv
  - verilog/line_draw.sv
  - verilog/triangle_fsm.sv
  - verilog/triangle_top.sv
  - target: test
    files:
      - tests/triangle_test_seq.sv
      - tests/triangle_checker.sv
      - tests/tb_triangle.sv
